// ==== design/aluControl.sv ====
/*
  ALU control
  maps the operation class and funct to one ALU operation
*/
`timescale 1ns/10ps
`default_nettype none

`include "mipsParams.svh"

module aluControl (
  input  mipsPkg::ctrlBus_t   ctrl,
  input  mipsPkg::instrWord_t ir,
  output mipsPkg::aluCtrl_t   aluOp
);

  import mipsPkg::*;

  always_comb begin
    case (ctrl.aluOp)
      // address arithmetic for lw and sw
      ALUOP_ADD: aluOp = ALU_ADD;
      // beq compare
      ALUOP_SUB: aluOp = ALU_SUB;
      ALUOP_FUNCT: begin
        case (ir.r.funct)
          `FN_ADD: aluOp = ALU_ADD;
          `FN_SUB: aluOp = ALU_SUB;
          `FN_AND: aluOp = ALU_AND;
          `FN_OR:  aluOp = ALU_OR;
          `FN_SLT: aluOp = ALU_SLT;
          // jr and unknown funct
          default: aluOp = ALU_NOP;
        endcase
      end
      default: aluOp = ALU_NOP;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/aluUnit.sv ====
/*
  ALU
  sign-extends the immediate, picks operand two and computes
  the result and the zero flag
*/
`timescale 1ns/10ps
`default_nettype none

`include "mipsParams.svh"

module aluUnit (
  input  mipsPkg::instrWord_t    ir,
  input  mipsPkg::ctrlBus_t      ctrl,
  input  mipsPkg::aluCtrl_t      aluOp,
  input  logic [`MIPS_XLEN-1:0] rsData,
  input  logic [`MIPS_XLEN-1:0] rtData,
  output logic [`MIPS_XLEN-1:0] aluResult,
  output logic                  aluZero
);

  import mipsPkg::*;

  logic [`MIPS_XLEN-1:0] immExt;
  logic [`MIPS_XLEN-1:0] opB;

  // 16-bit offset widened with its sign
  assign immExt = {{(`MIPS_XLEN-16){ir.i.imm[15]}}, ir.i.imm};

  // immediate for lw and sw, register otherwise
  assign opB = ctrl.aluSrc ? immExt : rtData;

  always_comb begin
    case (aluOp)
      ALU_AND: aluResult = rsData & opB;
      ALU_OR:  aluResult = rsData | opB;
      ALU_ADD: aluResult = rsData + opB;
      ALU_SUB: aluResult = rsData - opB;
      // two's complement compare
      ALU_SLT: aluResult = {{(`MIPS_XLEN-1){1'b0}}, ($signed(rsData) < $signed(opB))};
      default: aluResult = '0;
    endcase
  end

  // used by beq after subtraction
  assign aluZero = (aluResult == '0);

endmodule

`default_nettype wire

// ==== design/controlUnit.sv ====
/*
  Main decoder
  turns opcode, and funct for R-type, into the control bus
  unsupported encodings decode to an instruction with no effect
*/
`timescale 1ns/10ps
`default_nettype none

`include "mipsParams.svh"

module controlUnit (
  input  mipsPkg::instrWord_t ir,
  output mipsPkg::ctrlBus_t   ctrl
);

  import mipsPkg::*;

  always_comb begin
    // quiet defaults, nothing written and pc+4 next
    ctrl       = '0;
    ctrl.aluOp = ALUOP_ADD;
    case (ir.r.opcode)
      `OP_RTYPE: begin
        ctrl.aluOp = ALUOP_FUNCT;
        case (ir.r.funct)
          `FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT: begin
            // result lands in rd
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
          end
          `FN_JR: begin
            ctrl.jr = 1'b1;
          end
          // unknown funct writes nothing
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      `OP_LW: begin
        // base plus offset, memory data to rt
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      `OP_SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      `OP_BEQ: begin
        // compare rs against rt by subtraction
        ctrl.branch = 1'b1;
        ctrl.aluOp  = ALUOP_SUB;
      end
      `OP_J: begin
        ctrl.jump = 1'b1;
      end
      `OP_JAL: begin
        // link address goes to r31
        ctrl.jump     = 1'b1;
        ctrl.jal      = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl.regWrite = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/mipsParams.svh ====
/*
  MIPS core parameters
  widths, reset vector and the opcode and funct encodings
  shared by the blocks of the single-cycle core
*/
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// ==================================================
// widths and reset
// ==================================================
// data path and address width
`define MIPS_XLEN 32
// data memory word address bits, result bits 8 to 2
`define MIPS_DMEM_AW 7
// first fetch address
`define MIPS_RESET_PC 32'h0000_0000

// ==================================================
// opcodes, instruction bits 31 to 26
// ==================================================
`define OP_RTYPE 6'b000000
`define OP_LW 6'b100011
`define OP_SW 6'b101011
`define OP_BEQ 6'b000100
`define OP_J 6'b000010
`define OP_JAL 6'b000011

// funct codes for R-type, bits 5 to 0
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR 6'b100101
// signed compare
`define FN_SLT 6'b101010
`define FN_JR 6'b001000

`endif

// ==== design/mipsPkg.sv ====
/*
  MIPS core types
  instruction formats as one union, the decoded control bus
  and the ALU operation encodings
*/
`default_nettype none

package mipsPkg;

  // ==================================================
  // instruction formats
  // ==================================================
  // register format
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFormat_t;

  // immediate format, loads stores and branches
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFormat_t;

  // jump format
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jFormat_t;

  // one fetched word seen through each format
  typedef union packed {
    rFormat_t r;
    iFormat_t i;
    jFormat_t j;
  } instrWord_t;

  // ==================================================
  // ALU encodings
  // ==================================================
  // operation class from the main decoder
  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'b00,
    ALUOP_SUB   = 2'b01,
    ALUOP_FUNCT = 2'b10
  } aluOp_t;

  // operation seen by the ALU
  typedef enum logic [3:0] {
    ALU_AND = 4'b0000,
    ALU_OR  = 4'b0001,
    ALU_ADD = 4'b0010,
    ALU_SUB = 4'b0110,
    ALU_SLT = 4'b0111,
    ALU_NOP = 4'b1111
  } aluCtrl_t;

  // decoded control, 12 bits
  typedef struct packed {
    logic   regDst;
    logic   aluSrc;
    logic   memToReg;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   jump;
    logic   branch;
    logic   jal;
    logic   jr;
    aluOp_t aluOp;
  } ctrlBus_t;

endpackage

`default_nettype wire

// ==== design/pcUnit.sv ====
/*
  Program counter
  holds the fetch address and picks the next one from
  sequential, branch, jump and jump-register targets
*/
`timescale 1ns/10ps
`default_nettype none

`include "mipsParams.svh"

module pcUnit (
  input  logic                  clk,
  input  logic                  rst,
  input  mipsPkg::instrWord_t   ir,
  input  mipsPkg::ctrlBus_t     ctrl,
  input  logic                  aluZero,
  input  logic [`MIPS_XLEN-1:0] rsData,
  output logic [`MIPS_XLEN-1:0] pc,
  output logic [`MIPS_XLEN-1:0] pcPlus4
);

  // bytes per instruction
  localparam logic [`MIPS_XLEN-1:0] instrBytes = 4;

  logic [`MIPS_XLEN-1:0] pcNext;
  logic [`MIPS_XLEN-1:0] branchOff;
  logic [`MIPS_XLEN-1:0] jumpTarget;

  assign pcPlus4 = pc + instrBytes;

  // word offset, sign-extended and scaled to bytes
  assign branchOff = {{(`MIPS_XLEN-18){ir.i.imm[15]}}, ir.i.imm, 2'b00};

  // region bits kept from pc+4
  assign jumpTarget = {pcPlus4[`MIPS_XLEN-1:`MIPS_XLEN-4], ir.j.target, 2'b00};

  // jump wins over taken branch, then jr
  always_comb begin
    if (ctrl.jump) begin
      pcNext = jumpTarget;
    end else if (ctrl.branch && aluZero) begin
      pcNext = pcPlus4 + branchOff;
    end else if (ctrl.jr) begin
      pcNext = rsData;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
/*
  Register file
  31 general registers plus a hardwired zero, two read ports
  and one write port, with write address and data selection
*/
`timescale 1ns/10ps
`default_nettype none

`include "mipsParams.svh"

module regFile (
  input  logic                  clk,
  input  logic                  rst,
  input  mipsPkg::instrWord_t   ir,
  input  mipsPkg::ctrlBus_t     ctrl,
  input  logic [`MIPS_XLEN-1:0] aluResult,
  input  logic [`MIPS_XLEN-1:0] memReadData,
  input  logic [`MIPS_XLEN-1:0] pcPlus4,
  output logic [`MIPS_XLEN-1:0] rsData,
  output logic [`MIPS_XLEN-1:0] rtData,
  output logic [`MIPS_XLEN-1:0] rfWriteData,
  output logic                  rfWriteEn
);

  // r0 has no storage
  logic [`MIPS_XLEN-1:0] regs [1:31];
  logic [4:0]            wrAddr;

  // ==================================================
  // write side selection
  // ==================================================
  always_comb begin
    if (ctrl.regDst) begin
      wrAddr = ir.r.rd;
    end else if (ctrl.jal) begin
      // link register
      wrAddr = 5'd31;
    end else begin
      wrAddr = ir.r.rt;
    end
  end

  always_comb begin
    if (ctrl.jal) begin
      rfWriteData = pcPlus4;
    end else if (ctrl.memToReg) begin
      rfWriteData = memReadData;
    end else begin
      rfWriteData = aluResult;
    end
  end

  // writes to r0 are dropped
  assign rfWriteEn = ctrl.regWrite && (wrAddr != 5'd0);

  // read ports, r0 forced to zero
  assign rsData = (ir.r.rs == 5'd0) ? '0 : regs[ir.r.rs];
  assign rtData = (ir.r.rt == 5'd0) ? '0 : regs[ir.r.rt];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (rfWriteEn) begin
      regs[wrAddr] <= rfWriteData;
    end
  end

endmodule

`default_nettype wire

// ==== design/singleCycleMips.sv ====
/*
  Single-cycle MIPS core
  decoder, ALU, register file and PC joined to the instruction
  and data memory ports, one instruction per clock
*/
`timescale 1ns/10ps
`default_nettype none

`include "mipsParams.svh"

module singleCycleMips (
  input  logic                     clk,
  input  logic                     rst,
  input  mipsPkg::instrWord_t      ir,
  input  logic [`MIPS_XLEN-1:0]    memReadData,
  output logic [`MIPS_XLEN-1:0]    irAddr,
  output logic [`MIPS_XLEN-1:0]    rfWriteData,
  output logic [`MIPS_XLEN-1:0]    memWriteData,
  output logic                     rfWriteEn,
  output logic                     memCen,
  output logic                     memWen,
  output logic [`MIPS_DMEM_AW-1:0] memAddr
);

  import mipsPkg::*;

  ctrlBus_t              ctrl;
  aluCtrl_t              aluOp;
  logic [`MIPS_XLEN-1:0] aluResult;
  logic                  aluZero;
  logic [`MIPS_XLEN-1:0] rsData;
  logic [`MIPS_XLEN-1:0] rtData;
  logic [`MIPS_XLEN-1:0] pc;
  logic [`MIPS_XLEN-1:0] pcPlus4;

  // ==================================================
  // decode
  // ==================================================
  controlUnit ctrlDec (.ir(ir), .ctrl(ctrl));

  aluControl aluDec (.ctrl(ctrl), .ir(ir), .aluOp(aluOp));

  // ==================================================
  // datapath
  // ==================================================
  aluUnit alu (
    .ir       (ir),
    .ctrl     (ctrl),
    .aluOp    (aluOp),
    .rsData   (rsData),
    .rtData   (rtData),
    .aluResult(aluResult),
    .aluZero  (aluZero)
  );

  regFile regs (
    .clk        (clk),
    .rst        (rst),
    .ir         (ir),
    .ctrl       (ctrl),
    .aluResult  (aluResult),
    .memReadData(memReadData),
    .pcPlus4    (pcPlus4),
    .rsData     (rsData),
    .rtData     (rtData),
    .rfWriteData(rfWriteData),
    .rfWriteEn  (rfWriteEn)
  );

  pcUnit pcGen (
    .clk    (clk),
    .rst    (rst),
    .ir     (ir),
    .ctrl   (ctrl),
    .aluZero(aluZero),
    .rsData (rsData),
    .pc     (pc),
    .pcPlus4(pcPlus4)
  );

  // memory ports, strobes active low
  assign irAddr       = pc;
  assign memAddr      = aluResult[`MIPS_DMEM_AW+1:2];
  assign memWriteData = rtData;
  assign memCen       = ~(ctrl.memRead | ctrl.memWrite);
  assign memWen       = ~ctrl.memWrite;

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/mipsPkg.sv
design/controlUnit.sv
design/aluControl.sv
design/aluUnit.sv
design/regFile.sv
design/pcUnit.sv
design/singleCycleMips.sv
verif/mipsTb.sv

// ==== verif/mipsTb.sv ====
/*
  Testbench for the single-cycle MIPS core
  instruction memory from a program table, data memory as a
  preloaded array, expected values checked after every fetch
*/
`timescale 1ns/10ps
`default_nettype none

`include "mipsParams.svh"

module mipsTb;

  import mipsPkg::*;

  // one program step and what the core must show for it
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] addr;
    logic        wen;
    logic [31:0] wdata;
    logic        memWen;
  } progRow_t;

  localparam int nRows      = 22;
  localparam int nReads     = 3;
  // cycles from time zero including reset and read-back
  localparam int cycleLimit = nRows + 20;

  logic                     clk;
  logic                     rst;
  instrWord_t               ir;
  logic [`MIPS_XLEN-1:0]    memReadData;
  logic [`MIPS_XLEN-1:0]    irAddr;
  logic [`MIPS_XLEN-1:0]    rfWriteData;
  logic [`MIPS_XLEN-1:0]    memWriteData;
  logic                     rfWriteEn;
  logic                     memCen;
  logic                     memWen;
  logic [`MIPS_DMEM_AW-1:0] memAddr;

  logic [31:0] dmem [0:127];
  progRow_t    prog [0:nRows-1];
  logic [6:0]  readAddr [0:nReads-1];
  logic [31:0] readExp [0:nReads-1];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic        expCen;
  logic        isMemOp;
  logic [6:0]  expMemAddr;
  logic [31:0] expStore;
  // register contents as the table predicts them
  logic [31:0] expRegs [0:31];
  logic [4:0]  destReg;

  singleCycleMips UUT (
    .clk         (clk),
    .rst         (rst),
    .ir          (ir),
    .memReadData (memReadData),
    .irAddr      (irAddr),
    .rfWriteData (rfWriteData),
    .memWriteData(memWriteData),
    .rfWriteEn   (rfWriteEn),
    .memCen      (memCen),
    .memWen      (memWen),
    .memAddr     (memAddr)
  );

  // 8 ns period
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ==================================================
  // data memory model
  // ==================================================
  // combinational read and a write on the edge with both strobes low
  assign memReadData = dmem[memAddr];

  always @(posedge clk) begin
    if (!memCen && !memWen) begin
      dmem[memAddr] <= memWriteData;
    end
  end

  // background word that shows every address bit
  function automatic logic [31:0] fillWord(input logic [6:0] a);
    fillWord = {16'hC0DE, 9'd0, a};
  endfunction

  // instruction encoders
  function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] funct);
    encodeR = {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    encodeI = {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
    encodeJ = {op, target};
  endfunction

  function automatic progRow_t makeRow(input logic [31:0] instr, input logic [31:0] addr,
                                       input logic wen, input logic [31:0] wdata,
                                       input logic mWen);
    makeRow = {instr, addr, wen, wdata, mWen};
  endfunction

  // ==================================================
  // program table
  // ==================================================
  // dmem words 1..3 hold 7, 5 and -16
  task automatic loadProgram();
    // untouched registers sum to zero
    prog[0]  = makeRow(encodeR(5'd2, 5'd3, 5'd1, `FN_ADD), 32'h00, 1'b1, 32'h0, 1'b1);
    prog[1]  = makeRow(encodeI(`OP_LW, 5'd0, 5'd1, 16'd4), 32'h04, 1'b1, 32'h7, 1'b1);
    prog[2]  = makeRow(encodeI(`OP_LW, 5'd0, 5'd2, 16'd8), 32'h08, 1'b1, 32'h5, 1'b1);
    prog[3]  = makeRow(encodeI(`OP_LW, 5'd0, 5'd3, 16'd12), 32'h0C, 1'b1, 32'hFFFF_FFF0, 1'b1);
    // 7 + 5, 7 - 5, 7 & 5, 7 | -16
    prog[4]  = makeRow(encodeR(5'd1, 5'd2, 5'd4, `FN_ADD), 32'h10, 1'b1, 32'hC, 1'b1);
    prog[5]  = makeRow(encodeR(5'd1, 5'd2, 5'd5, `FN_SUB), 32'h14, 1'b1, 32'h2, 1'b1);
    prog[6]  = makeRow(encodeR(5'd1, 5'd2, 5'd6, `FN_AND), 32'h18, 1'b1, 32'h5, 1'b1);
    prog[7]  = makeRow(encodeR(5'd1, 5'd3, 5'd7, `FN_OR), 32'h1C, 1'b1, 32'hFFFF_FFF7, 1'b1);
    // signed compare of -16 and 7 both ways
    prog[8]  = makeRow(encodeR(5'd3, 5'd1, 5'd8, `FN_SLT), 32'h20, 1'b1, 32'h1, 1'b1);
    prog[9]  = makeRow(encodeR(5'd1, 5'd3, 5'd9, `FN_SLT), 32'h24, 1'b1, 32'h0, 1'b1);
    // store 12 to word 16 and load it back
    prog[10] = makeRow(encodeI(`OP_SW, 5'd0, 5'd4, 16'd64), 32'h28, 1'b0, 32'h0, 1'b0);
    prog[11] = makeRow(encodeI(`OP_LW, 5'd0, 5'd10, 16'd64), 32'h2C, 1'b1, 32'hC, 1'b1);
    // unknown funct then a write to r0
    prog[12] = makeRow(encodeR(5'd1, 5'd2, 5'd11, 6'h3F), 32'h30, 1'b0, 32'h0, 1'b1);
    prog[13] = makeRow(encodeR(5'd1, 5'd2, 5'd0, `FN_ADD), 32'h34, 1'b0, 32'h0, 1'b1);
    // taken beq lands on 60 + 8 and untaken falls through
    prog[14] = makeRow(encodeI(`OP_BEQ, 5'd1, 5'd1, 16'd2), 32'h38, 1'b0, 32'h0, 1'b1);
    prog[15] = makeRow(encodeI(`OP_BEQ, 5'd1, 5'd2, 16'd5), 32'h44, 1'b0, 32'h0, 1'b1);
    prog[16] = makeRow(encodeJ(`OP_J, 26'h40), 32'h48, 1'b0, 32'h0, 1'b1);
    // link value is 0x100 + 4
    prog[17] = makeRow(encodeJ(`OP_JAL, 26'h50), 32'h100, 1'b1, 32'h104, 1'b1);
    prog[18] = makeRow(encodeR(5'd31, 5'd0, 5'd0, `FN_JR), 32'h140, 1'b0, 32'h0, 1'b1);
    prog[19] = makeRow(encodeI(`OP_SW, 5'd0, 5'd7, 16'd68), 32'h104, 1'b0, 32'h0, 1'b0);
    prog[20] = makeRow(encodeI(`OP_LW, 5'd0, 5'd11, 16'd68), 32'h108, 1'b1, 32'hFFFF_FFF7, 1'b1);
    // -9 + 1
    prog[21] = makeRow(encodeR(5'd11, 5'd8, 5'd12, `FN_ADD), 32'h10C, 1'b1, 32'hFFFF_FFF8, 1'b1);
    // read-back after the program
    readAddr[0] = 7'd16;
    readExp[0]  = 32'hC;
    readAddr[1] = 7'd17;
    readExp[1]  = 32'hFFFF_FFF7;
    readAddr[2] = 7'd100;
    readExp[2]  = fillWord(7'd100);
  endtask

  // ==================================================
  // timeout
  // ==================================================
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    rst = 1'b0;
    ir  = '0;
    for (int a = 0; a < 128; a++) begin
      dmem[a] = fillWord(a[6:0]);
    end
    dmem[1] = 32'h0000_0007;
    dmem[2] = 32'h0000_0005;
    dmem[3] = 32'hFFFF_FFF0;
    // all registers clear on reset
    for (int r = 0; r < 32; r++) begin
      expRegs[r] = '0;
    end
    loadProgram();

    // fetch address pinned during reset
    repeat (2) @(posedge clk);
    #1;
    checks++;
    if (irAddr !== `MIPS_RESET_PC) begin
      $display("Fail irAddr in reset exp %h got %h", `MIPS_RESET_PC, irAddr);
      errors++;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b1;

    for (int i = 0; i < nRows; i++) begin
      checks++;
      if (irAddr !== prog[i].addr) begin
        $display("Fail irAddr row %0d exp %h got %h", i, prog[i].addr, irAddr);
        errors++;
      end
      ir = prog[i].instr;
      // chip enable low only for lw and sw
      isMemOp = (prog[i].instr[31:26] == `OP_LW) || (prog[i].instr[31:26] == `OP_SW);
      expCen  = !isMemOp;
      // every access in the table is based on r0
      expMemAddr = prog[i].instr[8:2];
      expStore   = expRegs[prog[i].instr[20:16]];
      #1;
      checks++;
      if (rfWriteEn !== prog[i].wen) begin
        $display("Fail rfWriteEn row %0d exp %h got %h", i, prog[i].wen, rfWriteEn);
        errors++;
      end
      if (prog[i].wen && (rfWriteData !== prog[i].wdata)) begin
        $display("Fail rfWriteData row %0d exp %h got %h", i, prog[i].wdata, rfWriteData);
        errors++;
      end
      if (memWen !== prog[i].memWen) begin
        $display("Fail memWen row %0d exp %h got %h", i, prog[i].memWen, memWen);
        errors++;
      end
      if (memCen !== expCen) begin
        $display("Fail memCen row %0d exp %h got %h", i, expCen, memCen);
        errors++;
      end
      if (isMemOp && (memAddr !== expMemAddr)) begin
        $display("Fail memAddr row %0d exp %h got %h", i, expMemAddr, memAddr);
        errors++;
      end
      // store data is the rt value left by earlier rows
      if ((prog[i].instr[31:26] == `OP_SW) && (memWriteData !== expStore)) begin
        $display("Fail memWriteData row %0d exp %h got %h", i, expStore, memWriteData);
        errors++;
      end
      // destination is rd for R-type, r31 for jal and rt for lw
      if (prog[i].wen) begin
        if (prog[i].instr[31:26] == `OP_RTYPE) begin
          destReg = prog[i].instr[15:11];
        end else if (prog[i].instr[31:26] == `OP_JAL) begin
          destReg = 5'd31;
        end else begin
          destReg = prog[i].instr[20:16];
        end
        expRegs[destReg] = prog[i].wdata;
      end
      @(posedge clk);
      #1;
    end

    // stored words seen again through lw into r13
    for (int k = 0; k < nReads; k++) begin
      ir = encodeI(`OP_LW, 5'd0, 5'd13, {7'd0, readAddr[k], 2'b00});
      #1;
      checks++;
      if (rfWriteData !== readExp[k]) begin
        $display("Fail rfWriteData read-back %0d exp %h got %h", k, readExp[k], rfWriteData);
        errors++;
      end
      @(posedge clk);
      #1;
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
